// ==== bus_pkg.sv ====
// Bus widths and state/response encodings shared by the no-cache AXI-Lite front end
package bus_pkg;

    // ==================================================
    // Bus widths
    // ==================================================

    // CPU and AXI address
    localparam int addr_width = 32;
    localparam int data_width = 32;
    // One strobe bit per byte lane
    localparam int strb_width = data_width / 8;
    localparam int resp_width = 2;

    // ==================================================
    // Encodings
    // ==================================================

    // No-cache unit states
    // Instruction unit walks only idle, read and done
    typedef enum logic [2:0] {
        st_idle,
        st_write,       // AW and W channels open together
        st_write_resp,
        st_read_addr,
        st_read_data,
        st_done
    } no_cache_state_t;

    // AXI response codes on bresp and rresp
    typedef enum logic [resp_width-1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

endpackage

// ==== axi_lite_if.sv ====
// AXI-Lite bus with all five channels and master, read-only master and slave views
interface axi_lite_if
    import bus_pkg::*;
();

    // Write address channel
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;

    // Write data channel
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;

    // Write response channel
    axi_resp_t             bresp;
    logic                  bvalid;
    logic                  bready;

    // Read address channel
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;

    // Read data channel
    logic [data_width-1:0] rdata;
    axi_resp_t             rresp;
    logic                  rvalid;
    logic                  rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    // Fetch side only needs the read channels
    modport read_master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// ==== data_no_cache.sv ====
// Uncached data port that turns CPU loads and stores into AXI-Lite reads and writes
module data_no_cache
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] address,
    input  logic [data_width-1:0] write_data,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [strb_width-1:0] byte_enable,
    output logic [data_width-1:0] read_data,
    output logic                  stall,
    axi_lite_if.master            axi
);

    no_cache_state_t       state;
    no_cache_state_t       next_state;
    logic                  aw_done;
    logic                  w_done;
    logic                  aw_fire;
    logic                  w_fire;
    logic [data_width-1:0] rdata_q;

    // ==================================================
    // AXI-Lite channel drive
    // ==================================================

    // CPU holds its request until stall drops, so payload comes straight through
    assign axi.awaddr  = address;
    assign axi.wdata   = write_data;
    assign axi.wstrb   = byte_enable;
    assign axi.araddr  = address;

    // Each write valid drops on its own handshake
    assign axi.awvalid = (state == st_write) && !aw_done;
    assign axi.wvalid  = (state == st_write) && !w_done;
    assign axi.bready  = (state == st_write_resp);
    assign axi.arvalid = (state == st_read_addr);
    assign axi.rready  = (state == st_read_data);

    assign aw_fire = axi.awvalid && axi.awready;
    assign w_fire  = axi.wvalid && axi.wready;

    // ==================================================
    // Request FSM
    // ==================================================

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                // Stores win over loads
                if (write_enable) begin
                    next_state = st_write;
                end else if (read_enable) begin
                    next_state = st_read_addr;
                end
            end
            st_write: begin
                if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                    next_state = st_write_resp;
                end
            end
            st_write_resp: begin
                if (axi.bvalid) begin
                    next_state = st_done;
                end
            end
            st_read_addr: begin
                if (axi.arready) begin
                    next_state = st_read_data;
                end
            end
            st_read_data: begin
                if (axi.rvalid) begin
                    next_state = st_done;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_idle) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_done <= 1'b1;
                end
                if (w_fire) begin
                    w_done <= 1'b1;
                end
            end
        end
    end

    // Load word held for the done cycle
    always_ff @(posedge clk) begin
        if (axi.rvalid && axi.rready) begin
            rdata_q <= axi.rdata;
        end
    end

    assign read_data = rdata_q;

    // High from the enable cycle until done
    assign stall = (state == st_idle) ? (read_enable || write_enable) : (state != st_done);

endmodule

// ==== instr_no_cache.sv ====
// Uncached fetch port that turns instruction fetches into AXI-Lite reads
module instr_no_cache
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [addr_width-1:0] fetch_address,
    input  logic                  fetch_enable,
    output logic [data_width-1:0] fetch_data,
    output logic                  fetch_stall,
    axi_lite_if.read_master       axi
);

    no_cache_state_t       state;
    no_cache_state_t       next_state;
    logic [data_width-1:0] fetch_q;

    // Fetch address held by the core while stalled
    assign axi.araddr  = fetch_address;
    assign axi.arvalid = (state == st_read_addr);
    assign axi.rready  = (state == st_read_data);

    // ==================================================
    // Fetch FSM
    // ==================================================

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (fetch_enable) begin
                    next_state = st_read_addr;
                end
            end
            st_read_addr: begin
                if (axi.arready) begin
                    next_state = st_read_data;
                end
            end
            st_read_data: begin
                if (axi.rvalid) begin
                    next_state = st_done;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Instruction word for the done cycle
    always_ff @(posedge clk) begin
        if (axi.rvalid && axi.rready) begin
            fetch_q <= axi.rdata;
        end
    end

    assign fetch_data  = fetch_q;
    assign fetch_stall = (state == st_idle) ? fetch_enable : (state != st_done);

endmodule

// ==== axi_lite_read_arbiter.sv ====
// Round-robin read arbiter joining fetch and data units onto one AXI-Lite master
module axi_lite_read_arbiter
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    axi_lite_if.slave instr_port,
    axi_lite_if.slave data_port,
    axi_lite_if.master bus
);

    logic instr_req;
    logic data_req;
    logic pick_data;
    logic sel_data;
    logic busy;
    // Current grant while busy, last winner otherwise
    logic last_grant;

    assign instr_req = instr_port.arvalid;
    assign data_req  = data_port.arvalid;

    // ==================================================
    // Grant selection
    // ==================================================

    // On a collision the port that lost last time goes first
    always_comb begin
        if (instr_req && data_req) begin
            pick_data = !last_grant;
        end else begin
            pick_data = data_req;
        end
    end

    // Locked from the grant cycle to the read data handshake
    assign sel_data = busy ? last_grant : pick_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            last_grant <= 1'b0;
        end else if (!busy) begin
            if (instr_req || data_req) begin
                busy       <= 1'b1;
                last_grant <= pick_data;
            end
        end else if (bus.rvalid && bus.rready) begin
            busy <= 1'b0;
        end
    end

    // ==================================================
    // Read channel mux
    // ==================================================

    assign bus.araddr  = sel_data ? data_port.araddr  : instr_port.araddr;
    assign bus.arvalid = sel_data ? data_port.arvalid : instr_port.arvalid;
    assign bus.rready  = sel_data ? data_port.rready  : instr_port.rready;

    // Only the granted side sees ready and valid
    assign instr_port.arready = !sel_data && bus.arready;
    assign data_port.arready  = sel_data && bus.arready;
    assign instr_port.rvalid  = !sel_data && bus.rvalid;
    assign data_port.rvalid   = sel_data && bus.rvalid;

    // Payload fans out to both
    assign instr_port.rdata = bus.rdata;
    assign instr_port.rresp = bus.rresp;
    assign data_port.rdata  = bus.rdata;
    assign data_port.rresp  = bus.rresp;

    // ==================================================
    // Write channels
    // ==================================================

    // Data unit owns the write side outright
    assign bus.awaddr  = data_port.awaddr;
    assign bus.awvalid = data_port.awvalid;
    assign bus.wdata   = data_port.wdata;
    assign bus.wstrb   = data_port.wstrb;
    assign bus.wvalid  = data_port.wvalid;
    assign bus.bready  = data_port.bready;

    assign data_port.awready = bus.awready;
    assign data_port.wready  = bus.wready;
    assign data_port.bresp   = bus.bresp;
    assign data_port.bvalid  = bus.bvalid;

endmodule

// ==== axi_translator.sv ====
// Top level joining the fetch and data no-cache units onto one AXI-Lite master port
module axi_translator
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // ==================================================
    // AXI-Lite master
    // ==================================================

    // Write address
    output logic [addr_width-1:0] axi_lite_awaddr,
    output logic                  axi_lite_awvalid,
    input  logic                  axi_lite_awready,

    // Write data
    output logic [data_width-1:0] axi_lite_wdata,
    output logic [strb_width-1:0] axi_lite_wstrb,
    output logic                  axi_lite_wvalid,
    input  logic                  axi_lite_wready,

    // Write response
    input  logic [resp_width-1:0] axi_lite_bresp,
    input  logic                  axi_lite_bvalid,
    output logic                  axi_lite_bready,

    // Read address
    output logic [addr_width-1:0] axi_lite_araddr,
    output logic                  axi_lite_arvalid,
    input  logic                  axi_lite_arready,

    // Read data
    input  logic [data_width-1:0] axi_lite_rdata,
    input  logic [resp_width-1:0] axi_lite_rresp,
    input  logic                  axi_lite_rvalid,
    output logic                  axi_lite_rready,

    // ==================================================
    // CPU ports
    // ==================================================

    // Instruction fetch
    input  logic [addr_width-1:0] fetch_address,
    input  logic                  fetch_enable,
    output logic [data_width-1:0] fetch_data,
    output logic                  fetch_stall,

    // Data load/store
    input  logic [addr_width-1:0] cpu_address,
    input  logic [data_width-1:0] cpu_write_data,
    input  logic                  cpu_read_enable,
    input  logic                  cpu_write_enable,
    input  logic [strb_width-1:0] cpu_byte_enable,
    output logic [data_width-1:0] cpu_read_data,
    output logic                  cpu_stall
);

    axi_lite_if instr_bus ();
    axi_lite_if data_bus ();
    axi_lite_if axi_bus ();

    // Unpack the shared master onto the top ports
    assign axi_lite_awaddr  = axi_bus.awaddr;
    assign axi_lite_awvalid = axi_bus.awvalid;
    assign axi_bus.awready  = axi_lite_awready;

    assign axi_lite_wdata   = axi_bus.wdata;
    assign axi_lite_wstrb   = axi_bus.wstrb;
    assign axi_lite_wvalid  = axi_bus.wvalid;
    assign axi_bus.wready   = axi_lite_wready;

    assign axi_bus.bresp    = axi_resp_t'(axi_lite_bresp);
    assign axi_bus.bvalid   = axi_lite_bvalid;
    assign axi_lite_bready  = axi_bus.bready;

    assign axi_lite_araddr  = axi_bus.araddr;
    assign axi_lite_arvalid = axi_bus.arvalid;
    assign axi_bus.arready  = axi_lite_arready;

    assign axi_bus.rdata    = axi_lite_rdata;
    assign axi_bus.rresp    = axi_resp_t'(axi_lite_rresp);
    assign axi_bus.rvalid   = axi_lite_rvalid;
    assign axi_lite_rready  = axi_bus.rready;

    instr_no_cache instr_no_cache_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch_address (fetch_address),
        .fetch_enable  (fetch_enable),
        .fetch_data    (fetch_data),
        .fetch_stall   (fetch_stall),
        .axi           (instr_bus)
    );

    data_no_cache data_no_cache_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .address      (cpu_address),
        .write_data   (cpu_write_data),
        .read_enable  (cpu_read_enable),
        .write_enable (cpu_write_enable),
        .byte_enable  (cpu_byte_enable),
        .read_data    (cpu_read_data),
        .stall        (cpu_stall),
        .axi          (data_bus)
    );

    axi_lite_read_arbiter read_arbiter_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_port (instr_bus),
        .data_port  (data_bus),
        .bus        (axi_bus)
    );

endmodule

// ==== tb_axi_lite_mem.sv ====
// AXI-Lite slave memory model with per-channel ready delays set by the testbench
module tb_axi_lite_mem
    import bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [1:0]            aw_delay,
    input  logic [1:0]            w_delay,
    input  logic [1:0]            b_delay,
    input  logic [1:0]            ar_delay,
    input  logic [1:0]            r_delay,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [resp_width-1:0] bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_width-1:0] rdata,
    output logic [resp_width-1:0] rresp,
    output logic                  rvalid,
    input  logic                  rready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [data_width-1:0] mem [256];
    logic [7:0]            aw_index;
    logic [7:0]            ar_index;
    logic [data_width-1:0] w_word;
    logic [data_width-1:0] w_mask;
    logic                  aw_got;
    logic                  w_got;
    logic                  b_pend;
    logic                  r_pend;
    logic [1:0]            aw_cnt;
    logic [1:0]            w_cnt;
    logic [1:0]            b_cnt;
    logic [1:0]            ar_cnt;
    logic [1:0]            r_cnt;

    // Reset contents, every bit of the word index shows up
    function automatic logic [data_width-1:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx, idx + 8'h3c};
    endfunction

    assign bresp = resp_okay;
    assign rresp = resp_okay;

    // ==================================================
    // Write side
    // ==================================================

    // Ready only ever rises while valid is high, so ready high means a handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_pend  <= 1'b0;
            aw_cnt  <= 2'd0;
            w_cnt   <= 2'd0;
            b_cnt   <= 2'd0;
        end else begin
            if (awready) begin
                awready  <= 1'b0;
                aw_got   <= 1'b1;
                aw_index <= awaddr[9:2];
            end else if (awvalid && !aw_got) begin
                if (aw_cnt >= aw_delay) begin
                    awready <= 1'b1;
                    aw_cnt  <= 2'd0;
                end else begin
                    aw_cnt <= aw_cnt + 2'd1;
                end
            end
            if (wready) begin
                wready <= 1'b0;
                w_got  <= 1'b1;
                w_word <= wdata;
                w_mask <= {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
            end else if (wvalid && !w_got) begin
                if (w_cnt >= w_delay) begin
                    wready <= 1'b1;
                    w_cnt  <= 2'd0;
                end else begin
                    w_cnt <= w_cnt + 2'd1;
                end
            end
            // Commit once both halves are in, then answer on B
            if (aw_got && w_got && !b_pend) begin
                mem[aw_index] <= (mem[aw_index] & ~w_mask) | (w_word & w_mask);
                b_pend        <= 1'b1;
            end else if (b_pend && !bvalid) begin
                if (b_cnt >= b_delay) begin
                    bvalid <= 1'b1;
                    b_cnt  <= 2'd0;
                end else begin
                    b_cnt <= b_cnt + 2'd1;
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

    // ==================================================
    // Read side
    // ==================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            r_pend  <= 1'b0;
            ar_cnt  <= 2'd0;
            r_cnt   <= 2'd0;
            rdata   <= '0;
        end else begin
            if (arready) begin
                arready  <= 1'b0;
                r_pend   <= 1'b1;
                ar_index <= araddr[9:2];
            end else if (arvalid && !r_pend) begin
                if (ar_cnt >= ar_delay) begin
                    arready <= 1'b1;
                    ar_cnt  <= 2'd0;
                end else begin
                    ar_cnt <= ar_cnt + 2'd1;
                end
            end
            if (r_pend && !rvalid) begin
                if (r_cnt >= r_delay) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[ar_index];
                    r_cnt  <= 2'd0;
                end else begin
                    r_cnt <= r_cnt + 2'd1;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_axi_translator.sv ====
// Testbench for the AXI-Lite translator against a shadow memory reference
module tb_axi_translator
    import bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles   = 8;
    // Byte enable write/read pairs, fetch sweep, collisions, random mix
    localparam int num_ops        = 16 * 2 + 32 + 8 + 200;
    localparam int timeout_cycles = num_ops * 40 + reset_cycles;

    logic                  clk;
    logic                  arst_n;
    logic [addr_width-1:0] axi_lite_awaddr;
    logic                  axi_lite_awvalid;
    logic                  axi_lite_awready;
    logic [data_width-1:0] axi_lite_wdata;
    logic [strb_width-1:0] axi_lite_wstrb;
    logic                  axi_lite_wvalid;
    logic                  axi_lite_wready;
    logic [resp_width-1:0] axi_lite_bresp;
    logic                  axi_lite_bvalid;
    logic                  axi_lite_bready;
    logic [addr_width-1:0] axi_lite_araddr;
    logic                  axi_lite_arvalid;
    logic                  axi_lite_arready;
    logic [data_width-1:0] axi_lite_rdata;
    logic [resp_width-1:0] axi_lite_rresp;
    logic                  axi_lite_rvalid;
    logic                  axi_lite_rready;
    logic [addr_width-1:0] fetch_address;
    logic                  fetch_enable;
    logic [data_width-1:0] fetch_data;
    logic                  fetch_stall;
    logic [addr_width-1:0] cpu_address;
    logic [data_width-1:0] cpu_write_data;
    logic                  cpu_read_enable;
    logic                  cpu_write_enable;
    logic [strb_width-1:0] cpu_byte_enable;
    logic [data_width-1:0] cpu_read_data;
    logic                  cpu_stall;
    logic [1:0]            aw_delay;
    logic [1:0]            w_delay;
    logic [1:0]            b_delay;
    logic [1:0]            ar_delay;
    logic [1:0]            r_delay;

    logic [data_width-1:0] shadow [256];
    logic [31:0]           rng_state = 32'd33;
    logic [data_width-1:0] data_expect [$];
    logic [data_width-1:0] fetch_expect [$];
    int                    cycle_count = 0;

    // Held-valid tracking on the top ports
    logic                  ar_wait = 1'b0;
    logic                  aw_wait = 1'b0;
    logic                  w_wait = 1'b0;
    logic [addr_width-1:0] ar_addr_q;
    logic [addr_width-1:0] aw_addr_q;
    logic [data_width-1:0] w_data_q;
    logic [strb_width-1:0] w_strb_q;

    axi_translator axi_translator_i (.*);

    tb_axi_lite_mem mem_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .aw_delay (aw_delay),
        .w_delay  (w_delay),
        .b_delay  (b_delay),
        .ar_delay (ar_delay),
        .r_delay  (r_delay),
        .awaddr   (axi_lite_awaddr),
        .awvalid  (axi_lite_awvalid),
        .awready  (axi_lite_awready),
        .wdata    (axi_lite_wdata),
        .wstrb    (axi_lite_wstrb),
        .wvalid   (axi_lite_wvalid),
        .wready   (axi_lite_wready),
        .bresp    (axi_lite_bresp),
        .bvalid   (axi_lite_bvalid),
        .bready   (axi_lite_bready),
        .araddr   (axi_lite_araddr),
        .arvalid  (axi_lite_arvalid),
        .arready  (axi_lite_arready),
        .rdata    (axi_lite_rdata),
        .rresp    (axi_lite_rresp),
        .rvalid   (axi_lite_rvalid),
        .rready   (axi_lite_rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Reference model and helpers
    // ==================================================

    function automatic logic [data_width-1:0] reset_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx, idx + 8'h3c};
    endfunction

    function automatic logic [data_width-1:0] expected_read(input logic [addr_width-1:0] addr);
        return shadow[addr[9:2]];
    endfunction

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    function automatic logic [addr_width-1:0] random_address();
        logic [15:0] r;
        r = next_random();
        return {22'd0, r[7:0], 2'b00};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("error at %0.1f ns: %s", $realtime, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    task automatic set_delays();
        logic [15:0] r;
        r = next_random();
        aw_delay = r[1:0];
        w_delay  = r[3:2];
        b_delay  = r[5:4];
        ar_delay = r[7:6];
        r_delay  = r[9:8];
    endtask

    // Only the enabled bytes of a store reach the word
    task automatic merge_write(input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] data,
                               input logic [strb_width-1:0] be);
        for (int b = 0; b < strb_width; b++) begin
            if (be[b]) begin
                shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic data_write(input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data,
                              input logic [strb_width-1:0] be);
        merge_write(addr, data, be);
        cpu_address      = addr;
        cpu_write_data   = data;
        cpu_byte_enable  = be;
        cpu_write_enable = 1'b1;
        @(negedge clk);
        while (cpu_stall) @(negedge clk);
        tick();
        cpu_write_enable = 1'b0;
    endtask

    task automatic data_read(input logic [addr_width-1:0] addr);
        data_expect.push_back(expected_read(addr));
        cpu_address     = addr;
        cpu_read_enable = 1'b1;
        @(negedge clk);
        while (cpu_stall) @(negedge clk);
        tick();
        cpu_read_enable = 1'b0;
    endtask

    task automatic fetch(input logic [addr_width-1:0] addr);
        fetch_expect.push_back(expected_read(addr));
        fetch_address = addr;
        fetch_enable  = 1'b1;
        @(negedge clk);
        while (fetch_stall) @(negedge clk);
        tick();
        fetch_enable = 1'b0;
    endtask

    // ==================================================
    // Checkers
    // ==================================================

    // Read data is valid in the cycle stall drops
    always @(negedge clk) begin
        if (arst_n && cpu_read_enable && !cpu_write_enable && !cpu_stall) begin
            assert (data_expect.size() > 0 && cpu_read_data == data_expect[0])
            else stop_on_error($sformatf("load at %h returned %h, expected %h",
                                         cpu_address, cpu_read_data, data_expect[0]));
            void'(data_expect.pop_front());
        end
        if (arst_n && fetch_enable && !fetch_stall) begin
            assert (fetch_expect.size() > 0 && fetch_data == fetch_expect[0])
            else stop_on_error($sformatf("fetch at %h returned %h, expected %h",
                                         fetch_address, fetch_data, fetch_expect[0]));
            void'(fetch_expect.pop_front());
        end
    end

    // Valid without ready at one sample must hold, payload unchanged, at the next
    always @(negedge clk) begin
        if (arst_n) begin
            if (ar_wait) begin
                assert (axi_lite_arvalid && axi_lite_araddr == ar_addr_q)
                else stop_on_error("arvalid dropped or araddr changed before arready");
            end
            if (aw_wait) begin
                assert (axi_lite_awvalid && axi_lite_awaddr == aw_addr_q)
                else stop_on_error("awvalid dropped or awaddr changed before awready");
            end
            if (w_wait) begin
                assert (axi_lite_wvalid && axi_lite_wdata == w_data_q
                        && axi_lite_wstrb == w_strb_q)
                else stop_on_error("wvalid dropped or wdata/wstrb changed before wready");
            end
            ar_wait   = axi_lite_arvalid && !axi_lite_arready;
            aw_wait   = axi_lite_awvalid && !axi_lite_awready;
            w_wait    = axi_lite_wvalid && !axi_lite_wready;
            ar_addr_q = axi_lite_araddr;
            aw_addr_q = axi_lite_awaddr;
            w_data_q  = axi_lite_wdata;
            w_strb_q  = axi_lite_wstrb;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [addr_width-1:0] addr;
        logic [addr_width-1:0] other;
        logic [data_width-1:0] wdata;
        logic [15:0]           r;
        arst_n           = 1'b0;
        fetch_address    = '0;
        fetch_enable     = 1'b0;
        cpu_address      = '0;
        cpu_write_data   = '0;
        cpu_read_enable  = 1'b0;
        cpu_write_enable = 1'b0;
        cpu_byte_enable  = '0;
        aw_delay         = 2'd0;
        w_delay          = 2'd0;
        b_delay          = 2'd0;
        ar_delay         = 2'd0;
        r_delay          = 2'd0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = reset_word(8'(i));
        end
        repeat (reset_cycles) @(posedge clk);
        #0.5;
        arst_n = 1'b1;

        // Quiet bus after reset
        @(negedge clk);
        assert (!axi_lite_awvalid && !axi_lite_wvalid && !axi_lite_arvalid
                && !axi_lite_bready && !axi_lite_rready && !fetch_stall && !cpu_stall)
        else stop_on_error("bus valid, ready or stall active after reset with enables low");
        tick();

        // Every byte enable pattern on its own word, read back
        for (int be = 0; be < 16; be++) begin
            set_delays();
            wdata = {next_random(), next_random()};
            data_write({26'd0, 4'(be), 2'b00}, wdata, 4'(be));
            set_delays();
            data_read({26'd0, 4'(be), 2'b00});
        end

        // Words 0 to 15 were written, 16 to 31 keep the reset pattern
        for (int i = 0; i < 32; i++) begin
            set_delays();
            fetch({25'd0, 5'(i), 2'b00});
        end

        // Fetch and load on the same cycle
        for (int i = 0; i < 8; i++) begin
            set_delays();
            addr  = random_address();
            other = random_address();
            fork
                fetch(addr);
                data_read(other);
            join
        end

        for (int n = 0; n < 200; n++) begin
            set_delays();
            r     = next_random();
            addr  = random_address();
            other = random_address();
            wdata = {next_random(), next_random()};
            case (r[2:0])
                3'd0, 3'd1: fetch(addr);
                3'd2: data_read(addr);
                3'd3, 3'd4: data_write(addr, wdata, r[6:3]);
                3'd5: begin
                    fork
                        fetch(other);
                        data_read(addr);
                    join
                end
                default: begin
                    // Fetch stays off the word being stored
                    if (other[9:2] == addr[9:2]) begin
                        other[9:2] = addr[9:2] + 8'd1;
                    end
                    fork
                        data_write(addr, wdata, r[6:3]);
                        fetch(other);
                    join
                end
            endcase
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verilog.f ====
bus_pkg.sv
axi_lite_if.sv
data_no_cache.sv
instr_no_cache.sv
axi_lite_read_arbiter.sv
axi_translator.sv
tb_axi_lite_mem.sv
tb_axi_translator.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_axi_translator
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)
